/* Bender.yml */
package:
  name: lsu_resp_sub

sources:
  # Shared package
  - files:
      - src/lsu_pkg.sv
  # Design sources
  - files:
      - src/lsu_req_fsm.sv
      - src/outstanding_counter.sv
      - src/resp_type_queue.sv
      - src/lsu_resp_filter.sv
      - src/lsu_resp_sub.sv
  # Testbench sources
  - target: test
    files:
      - testbench/lsu_resp_sub_assertions.sv
      - testbench/tb_lsu_resp_sub.sv

/* lsu_resp_sub.f */
src/lsu_pkg.sv
src/lsu_req_fsm.sv
src/outstanding_counter.sv
src/resp_type_queue.sv
src/lsu_resp_filter.sv
src/lsu_resp_sub.sv
testbench/lsu_resp_sub_assertions.sv
testbench/tb_lsu_resp_sub.sv

/* src/lsu_pkg.sv */
// Shared widths and enums for the LSU data-side bus interface
// Imported by the request FSM, the response filter and the top level

package lsu_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Byte address width on the data bus
  parameter int unsigned ADDR_W = 32;

  // Write data and read data width
  parameter int unsigned DATA_W = 32;

  //////////////////////////////////////////////////
  // Opcodes and states
  //////////////////////////////////////////////////

  // Memory operation of one transfer
  // The store encoding doubles as the bus write enable
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } lsu_op_e;

  // Request FSM states
  // ST_HOLD means the holding register has a request for the filter
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_HOLD = 1'b1
  } req_state_e;

endpackage : lsu_pkg

/* src/lsu_req_fsm.sv */
// Request FSM between the core and the response filter
// Captures one core request into a holding register and presents it one cycle later

`timescale 1ns/1ps

module lsu_req_fsm
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // Core side
  input  logic              core_req_i,
  input  lsu_op_e           core_op_i,
  input  logic              core_bufferable_i,
  input  logic [ADDR_W-1:0] core_addr_i,
  input  logic [DATA_W-1:0] core_wdata_i,
  output logic              core_gnt_o,
  // Filter side
  output logic              req_valid_o,
  output lsu_op_e           req_op_o,
  output logic              req_bufferable_o,
  output logic [ADDR_W-1:0] req_addr_o,
  output logic [DATA_W-1:0] req_wdata_o,
  input  logic              req_ready_i
);

  req_state_e state_q;
  req_state_e state_d;
  logic       capture;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    capture = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // Take a new request straight away
        if (core_req_i) begin
          capture = 1'b1;
          state_d = ST_HOLD;
        end
      end
      ST_HOLD: begin
        // Held request accepted, refill from the core if one is waiting
        if (req_ready_i) begin
          if (core_req_i) begin
            capture = 1'b1;
          end else begin
            state_d = ST_IDLE;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Grant in the capture cycle
  assign core_gnt_o  = capture;
  assign req_valid_o = (state_q == ST_HOLD);

  //////////////////////////////////////////////////
  // State and holding register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q          <= ST_IDLE;
      req_op_o         <= OP_LOAD;
      req_bufferable_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        req_op_o <= core_op_i;
        // Early response only makes sense for stores
        req_bufferable_o <= core_bufferable_i && (core_op_i == OP_STORE);
      end
    end
  end

  // Address and write data carry no reset
  always_ff @(posedge clk) begin
    if (capture) begin
      req_addr_o  <= core_addr_i;
      req_wdata_o <= core_wdata_i;
    end
  end

endmodule : lsu_req_fsm

/* src/lsu_resp_filter.sv */
// Response filter for up to DEPTH outstanding bus transfers
// Gives early core valid to bufferable stores and forms the bus error flags

`timescale 1ns/1ps

module lsu_resp_filter
  import lsu_pkg::*;
#(
  parameter int unsigned DEPTH = 2
) (
  input  logic       clk,
  input  logic       rst_n,
  // From the request FSM
  input  logic       req_valid_i,
  input  lsu_op_e    req_op_i,
  input  logic       req_bufferable_i,
  output logic       req_ready_o,
  // Bus strobes
  input  logic       bus_gnt_i,
  input  logic       bus_rvalid_i,
  input  logic       bus_err_i,
  output logic       bus_req_o,
  // Core response side
  output logic       core_rvalid_o,
  output logic       busy_o,
  // Bit 0 error flag, bit 1 set for a store
  output logic [1:0] bus_error_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [CNT_W-1:0] bus_cnt;
  logic [CNT_W-1:0] core_cnt;
  logic             has_room;
  logic             accepted;
  logic             bus_bufferable;
  lsu_op_e          bus_op;
  logic             core_bufferable;

  //////////////////////////////////////////////////
  // Flow control
  //////////////////////////////////////////////////

  // Block new transfers once DEPTH are out on the bus
  assign has_room    = (bus_cnt < DEPTH);
  assign req_ready_o = bus_gnt_i && has_room;
  assign bus_req_o   = req_valid_i && has_room;
  // Same event seen from both sides
  assign accepted    = bus_req_o && bus_gnt_i;

  assign busy_o = (bus_cnt != '0) || req_valid_i;

  // Bus side count drops on each bus response
  outstanding_counter #(.CNT_W(CNT_W)) bus_counter_i (
    .clk   (clk),
    .rst_n (rst_n),
    .inc_i (accepted),
    .dec_i (bus_rvalid_i),
    .cnt_o (bus_cnt)
  );

  // Core side count drops on each core response, early or not
  outstanding_counter #(.CNT_W(CNT_W)) core_counter_i (
    .clk   (clk),
    .rst_n (rst_n),
    .inc_i (accepted),
    .dec_i (core_rvalid_o),
    .cnt_o (core_cnt)
  );

  resp_type_queue #(.DEPTH(DEPTH), .CNT_W(CNT_W)) type_queue_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_i            (accepted),
    .push_bufferable_i (req_bufferable_i),
    .push_op_i         (req_op_i),
    .bus_idx_i         (bus_cnt),
    .core_idx_i        (core_cnt),
    .bus_bufferable_o  (bus_bufferable),
    .bus_op_o          (bus_op),
    .core_bufferable_o (core_bufferable)
  );

  //////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////

  // Bufferable oldest on the bus side, answer the core on its own oldest flag
  // Otherwise wait for the real bus response
  assign core_rvalid_o  = bus_bufferable ? core_bufferable : bus_rvalid_i;
  assign bus_error_o[0] = bus_rvalid_i && bus_err_i;
  assign bus_error_o[1] = (bus_op == OP_STORE);

endmodule : lsu_resp_filter

/* src/lsu_resp_sub.sv */
// Top level of the LSU data-side bus interface
// Connects the request FSM and the response filter to the core and bus ports

`timescale 1ns/1ps

module lsu_resp_sub
  import lsu_pkg::*;
#(
  parameter int unsigned DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  // Core request
  input  logic              core_req_i,
  input  lsu_op_e           core_op_i,
  input  logic              core_bufferable_i,
  input  logic [ADDR_W-1:0] core_addr_i,
  input  logic [DATA_W-1:0] core_wdata_i,
  output logic              core_gnt_o,
  // Core response
  output logic              core_rvalid_o,
  output logic [DATA_W-1:0] core_rdata_o,
  output logic              busy_o,
  output logic [1:0]        bus_error_o,
  // Bus request
  output logic              bus_req_o,
  output logic              bus_we_o,
  output logic [ADDR_W-1:0] bus_addr_o,
  output logic [DATA_W-1:0] bus_wdata_o,
  input  logic              bus_gnt_i,
  // Bus response
  input  logic              bus_rvalid_i,
  input  logic [DATA_W-1:0] bus_rdata_i,
  input  logic              bus_err_i
);

  // FSM to filter
  logic    req_valid;
  lsu_op_e req_op;
  logic    req_bufferable;
  logic    req_ready;

  lsu_req_fsm req_fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_i        (core_req_i),
    .core_op_i         (core_op_i),
    .core_bufferable_i (core_bufferable_i),
    .core_addr_i       (core_addr_i),
    .core_wdata_i      (core_wdata_i),
    .core_gnt_o        (core_gnt_o),
    .req_valid_o       (req_valid),
    .req_op_o          (req_op),
    .req_bufferable_o  (req_bufferable),
    .req_addr_o        (bus_addr_o),
    .req_wdata_o       (bus_wdata_o),
    .req_ready_i       (req_ready)
  );

  lsu_resp_filter #(.DEPTH(DEPTH)) resp_filter_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid_i      (req_valid),
    .req_op_i         (req_op),
    .req_bufferable_i (req_bufferable),
    .req_ready_o      (req_ready),
    .bus_gnt_i        (bus_gnt_i),
    .bus_rvalid_i     (bus_rvalid_i),
    .bus_err_i        (bus_err_i),
    .bus_req_o        (bus_req_o),
    .core_rvalid_o    (core_rvalid_o),
    .busy_o           (busy_o),
    .bus_error_o      (bus_error_o)
  );

  // Write enable straight from the held op
  assign bus_we_o     = (req_op == OP_STORE);
  // Read data returns unchanged and in order
  assign core_rdata_o = bus_rdata_i;

endmodule : lsu_resp_sub

/* src/outstanding_counter.sv */
// Up/down count of transfers accepted but not yet answered
// One instance per side of the response filter

`timescale 1ns/1ps

module outstanding_counter #(
  parameter int unsigned CNT_W = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  // One more transfer accepted
  input  logic             inc_i,
  // One response returned
  input  logic             dec_i,
  output logic [CNT_W-1:0] cnt_o
);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  // Accept and response in one cycle cancel out
  always_comb begin
    cnt_d = cnt_q;
    case ({inc_i, dec_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // The filter keeps the count within 0 to DEPTH
  assign cnt_o = cnt_q;

endmodule : outstanding_counter

/* src/resp_type_queue.sv */
// Shift register of response types for outstanding transfers
// Read at the bus-side and core-side counts to find each side's oldest transfer

`timescale 1ns/1ps

module resp_type_queue
  import lsu_pkg::*;
#(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned CNT_W = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  // Accepted transfer and its type
  input  logic             push_i,
  input  logic             push_bufferable_i,
  input  lsu_op_e          push_op_i,
  // Read indices, equal to the outstanding counts
  input  logic [CNT_W-1:0] bus_idx_i,
  input  logic [CNT_W-1:0] core_idx_i,
  output logic             bus_bufferable_o,
  output lsu_op_e          bus_op_o,
  output logic             core_bufferable_o
);

  // Entries 1 to DEPTH hold transfers, newest at 1
  // Entry 0 is never written and reads as a non-bufferable load
  logic [DEPTH:0] buf_q;
  logic [DEPTH:0] store_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_q   <= '0;
      store_q <= '0;
    end else if (push_i) begin
      // Older entries move one step deeper
      buf_q[DEPTH:1]   <= buf_q[DEPTH-1:0];
      store_q[DEPTH:1] <= store_q[DEPTH-1:0];
      buf_q[1]         <= push_bufferable_i;
      store_q[1]       <= (push_op_i == OP_STORE);
    end
  end

  //////////////////////////////////////////////////
  // Oldest entry per side
  //////////////////////////////////////////////////

  assign bus_bufferable_o  = buf_q[bus_idx_i];
  assign bus_op_o          = store_q[bus_idx_i] ? OP_STORE : OP_LOAD;
  assign core_bufferable_o = buf_q[core_idx_i];

endmodule : resp_type_queue

/* testbench/lsu_resp_sub_assertions.sv */
// Concurrent checks on the request FSM and response filter
// Bound into the top level so it sees both submodules

`timescale 1ns/1ps

module lsu_resp_sub_assertions
  import lsu_pkg::*;
#(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input logic              clk,
  input logic              rst_n,
  input logic              core_req_i,
  input logic              core_gnt_o,
  input logic              bus_req_o,
  input logic [ADDR_W-1:0] bus_addr_o,
  input logic              busy_o,
  input logic              req_valid,
  input logic              req_ready,
  input req_state_e        state_q,
  input logic [CNT_W-1:0]  bus_cnt,
  input logic [CNT_W-1:0]  core_cnt
);

  // No bus request once DEPTH transfers are out
  assert property (@(posedge clk) disable iff (!rst_n) bus_req_o |-> (bus_cnt != DEPTH))
    else $error("bus request with the outstanding limit reached");

  // Grant only answers a live core request
  assert property (@(posedge clk) disable iff (!rst_n) core_gnt_o |-> core_req_i)
    else $error("core grant without a core request");

  assert property (@(posedge clk) disable iff (!rst_n)
                   ((bus_cnt != '0) || (core_cnt != '0)) |-> busy_o)
    else $error("busy low with transfers outstanding");

  // Held request stays put until the filter takes it
  assert property (@(posedge clk) disable iff (!rst_n)
                   (req_valid && !req_ready) |=>
                   ((state_q == ST_HOLD) && $stable(bus_addr_o)))
    else $error("held request changed before acceptance");

endmodule : lsu_resp_sub_assertions

bind lsu_resp_sub lsu_resp_sub_assertions #(.DEPTH(DEPTH)) assertions_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .core_req_i (core_req_i),
  .core_gnt_o (core_gnt_o),
  .bus_req_o  (bus_req_o),
  .bus_addr_o (bus_addr_o),
  .busy_o     (busy_o),
  .req_valid  (req_valid),
  .req_ready  (req_ready),
  .state_q    (req_fsm_i.state_q),
  .bus_cnt    (resp_filter_i.bus_cnt),
  .core_cnt   (resp_filter_i.core_cnt)
);

/* testbench/tb_lsu_resp_sub.sv */
// Testbench for the LSU data-side bus interface
// Table-driven core requests, an in-order bus responder model and a response scoreboard

`timescale 1ns/1ps

module tb_lsu_resp_sub;
  import lsu_pkg::*;

  localparam int unsigned DEPTH = 2;
  localparam logic [DATA_W-1:0] RDATA_KEY = 32'h5A5A_A5A5;
  localparam int TIMEOUT = 300;

  typedef struct {
    int                test;
    lsu_op_e           op;
    logic              bufferable;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              err;
    int                gnt_dly;
    int                rsp_dly;
    logic [DATA_W-1:0] exp_rdata;
  } row_t;

  logic clk, rst_n;
  logic core_req_i, core_bufferable_i;
  lsu_op_e core_op_i;
  logic [ADDR_W-1:0] core_addr_i, bus_addr_o;
  logic [DATA_W-1:0] core_wdata_i, core_rdata_o, bus_wdata_o, bus_rdata_i;
  logic core_gnt_o, core_rvalid_o, busy_o, bus_req_o, bus_we_o;
  logic [1:0] bus_error_o;
  logic bus_gnt_i, bus_rvalid_i, bus_err_i;

  row_t rows[$];
  // Scoreboard: table index and transfer id per expected core response
  int exp_idx[$];
  int exp_id[$];
  // Rows granted to the core and waiting for bus acceptance
  int bus_rows[$];
  // Responder queue of accepted transfers
  int rsp_idx[$];
  int rsp_due[$];
  int cyc, next_id, acc_cnt, bus_resp_cnt, errors, checks;
  logic bp_seen;
  logic [31:0] rng_state;

  lsu_resp_sub #(.DEPTH(DEPTH)) lsu_resp_sub_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////

  task automatic check_rdata(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_op_error(input lsu_op_e exp_op, input logic exp_err);
    logic [1:0] exp;
    exp = {exp_op == OP_STORE, exp_err};
    checks++;
    if (bus_error_o !== exp) begin
      errors++;
      $display("FAILED bus_error_o got 0x%0h expected 0x%0h", bus_error_o, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Ordering and flow rules with no single signal behind them
  task automatic expect_true(input logic ok, input string what);
    checks++;
    if (ok !== 1'b1) begin
      errors++;
      $display("%s", what);
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Read data expected for a load is a fixed function of its address
  function automatic void add_row(input int test, input lsu_op_e op, input logic b,
                                  input logic [ADDR_W-1:0] addr, input logic err,
                                  input int gd, input int rd);
    row_t r;
    r.test = test;
    r.op = op;
    r.bufferable = b;
    r.addr = addr;
    r.wdata = ~addr;
    r.err = err;
    r.gnt_dly = gd;
    r.rsp_dly = rd;
    r.exp_rdata = addr ^ RDATA_KEY;
    rows.push_back(r);
  endfunction

  ////////////////////////////////////////////////////
  // Bus responder and response monitor
  ////////////////////////////////////////////////////

  // Samples at the falling edge, drives 2 ns after the rising edge
  initial begin : bus_responder
    int wait_cnt;
    int i;
    int head;
    bus_gnt_i = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i = '0;
    bus_err_i = 1'b0;
    wait_cnt = 0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        // Core response first, it reads the bus response count of earlier cycles
        if (core_rvalid_o) begin
          if (exp_idx.size() == 0) begin
            errors++;
            $display("core response seen with no request outstanding");
          end else begin
            i = exp_idx.pop_front();
            head = exp_id.pop_front();
            if (rows[i].op == OP_LOAD) begin
              check_rdata("core_rdata_o", core_rdata_o, rows[i].exp_rdata);
            end
            // Bufferable only counts for stores
            if (!(rows[i].bufferable && rows[i].op == OP_STORE)) begin
              check_flag("bus_rvalid_i", bus_rvalid_i, 1'b1);
              expect_true(bus_resp_cnt == head,
                          "core response not paired with its own bus response");
            end else if (rows[i].rsp_dly >= 6) begin
              // Early valid with its own bus response still pending
              expect_true((bus_resp_cnt + bus_rvalid_i) <= head,
                          "bufferable store answered only with its bus response");
            end
          end
        end
        if (bus_rvalid_i) begin
          i = rsp_idx.pop_front();
          void'(rsp_due.pop_front());
          check_op_error(rows[i].op, rows[i].err);
          bus_resp_cnt++;
        end
        if (bus_req_o && bus_gnt_i) begin
          i = bus_rows.pop_front();
          check_rdata("bus_addr_o", bus_addr_o, rows[i].addr);
          check_flag("bus_we_o", bus_we_o, rows[i].op == OP_STORE);
          if (rows[i].op == OP_STORE) begin
            check_rdata("bus_wdata_o", bus_wdata_o, rows[i].wdata);
          end
          rsp_idx.push_back(i);
          rsp_due.push_back(cyc + ((rows[i].rsp_dly < 1) ? 1 : rows[i].rsp_dly));
          acc_cnt++;
          wait_cnt = 0;
        end else if (bus_req_o) begin
          wait_cnt++;
        end
        expect_true((acc_cnt - bus_resp_cnt) <= DEPTH,
                    "more than DEPTH transfers outstanding on the bus");
        if (acc_cnt != bus_resp_cnt) begin
          check_flag("busy_o", busy_o, 1'b1);
        end
        if (core_req_i && !core_gnt_o && (acc_cnt - bus_resp_cnt) == DEPTH) begin
          bp_seen = 1'b1;
        end
      end
      @(posedge clk);
      cyc++;
      #2;
      bus_gnt_i = (bus_rows.size() > 0) && (wait_cnt >= rows[bus_rows[0]].gnt_dly);
      if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
        bus_rvalid_i = 1'b1;
        bus_rdata_i = rows[rsp_idx[0]].addr ^ RDATA_KEY;
        bus_err_i = rows[rsp_idx[0]].err;
      end else begin
        bus_rvalid_i = 1'b0;
        bus_rdata_i = '0;
        bus_err_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Core driver
  ////////////////////////////////////////////////////

  // Entered and left 2 ns after a rising edge
  task automatic issue_row(input int i);
    int n;
    core_req_i = 1'b1;
    core_op_i = rows[i].op;
    core_bufferable_i = rows[i].bufferable;
    core_addr_i = rows[i].addr;
    core_wdata_i = rows[i].wdata;
    n = 0;
    while (n < TIMEOUT) begin
      @(negedge clk);
      if (core_gnt_o) begin
        bus_rows.push_back(i);
        exp_idx.push_back(i);
        exp_id.push_back(next_id);
        next_id++;
        break;
      end
      n++;
      @(posedge clk);
      #2;
    end
    if (n == TIMEOUT) begin
      errors++;
      $display("timeout waiting for core grant on row %0d", i);
    end else begin
      @(posedge clk);
      #2;
    end
    core_req_i = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (n < TIMEOUT) begin
      @(negedge clk);
      if (exp_idx.size() == 0 && rsp_due.size() == 0 && bus_rows.size() == 0) begin
        break;
      end
      n++;
    end
    if (n == TIMEOUT) begin
      errors++;
      $display("timeout waiting for outstanding responses to drain");
    end
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    string names[1:6];
    int err_before;
    names[1] = "single load";
    names[2] = "bufferable store early valid";
    names[3] = "outstanding limit";
    names[4] = "bus error type";
    names[5] = "busy drain";
    names[6] = "random mix";
    rst_n = 1'b0;
    core_req_i = 1'b0;
    core_op_i = OP_LOAD;
    core_bufferable_i = 1'b0;
    core_addr_i = '0;
    core_wdata_i = '0;
    cyc = 0;
    next_id = 0;
    acc_cnt = 0;
    bus_resp_cnt = 0;
    errors = 0;
    checks = 0;
    bp_seen = 1'b0;
    rng_state = 32'd29;

    //     test op        buf   addr          err   gnt rsp
    add_row(1, OP_LOAD,  1'b0, 32'h0000_0100, 1'b0, 1, 2);
    add_row(2, OP_STORE, 1'b1, 32'h0000_0200, 1'b0, 0, 10);
    add_row(2, OP_LOAD,  1'b0, 32'h0000_0204, 1'b0, 1, 1);
    add_row(2, OP_STORE, 1'b0, 32'h0000_0208, 1'b0, 0, 3);
    add_row(3, OP_LOAD,  1'b0, 32'h0000_0300, 1'b0, 0, 12);
    add_row(3, OP_LOAD,  1'b0, 32'h0000_0304, 1'b0, 0, 12);
    add_row(3, OP_LOAD,  1'b0, 32'h0000_0308, 1'b0, 0, 12);
    add_row(3, OP_LOAD,  1'b0, 32'h0000_030C, 1'b0, 0, 12);
    add_row(4, OP_STORE, 1'b0, 32'h0000_0400, 1'b1, 1, 2);
    add_row(4, OP_LOAD,  1'b0, 32'h0000_0404, 1'b1, 0, 1);
    add_row(4, OP_STORE, 1'b1, 32'h0000_0408, 1'b1, 2, 2);
    add_row(5, OP_STORE, 1'b0, 32'h0000_0500, 1'b0, 3, 4);
    // Random rows, response delay kept short
    for (int k = 0; k < 16; k++) begin
      lsu_op_e op;
      rng_state = xorshift(rng_state);
      op = rng_state[0] ? OP_STORE : OP_LOAD;
      add_row(6, op, rng_state[1], xorshift(rng_state ^ 32'h1234_5678),
              rng_state[4:2] == 3'd0, rng_state[6:5], 1 + rng_state[8:7]);
    end

    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_flag("busy_o", busy_o, 1'b0);

    for (int t = 1; t <= 6; t++) begin
      err_before = errors;
      bp_seen = 1'b0;
      for (int i = 0; i < rows.size(); i++) begin
        if (rows[i].test == t) begin
          issue_row(i);
        end
      end
      drain();
      if (t == 3) begin
        expect_true(bp_seen, "no core request was held off by a full bus");
      end
      check_flag("busy_o", busy_o, 1'b0);
      $display("test %0d %s: %0s", t, names[t], (errors == err_before) ? "ok" : "errors");
    end

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_lsu_resp_sub
